// ==== include/wh_settings.svh ====
/*
  Wormhole endpoint settings
  Link, header field and packet widths shared by the receive
  endpoint RTL and its testbench. Packet width covers the largest
  packet the length field can describe.
*/

`ifndef WH_SETTINGS_SVH
`define WH_SETTINGS_SVH

// Width of one flit on a link
`define WH_LINK_WIDTH 16

// Header fields
`define WH_CORD_WIDTH 5
`define WH_LEN_WIDTH 2

// Header plus up to three body flits
`define WH_MAX_FLITS (1 << `WH_LEN_WIDTH)

// Fully assembled packet word
`define WH_PACKET_WIDTH (`WH_MAX_FLITS * `WH_LINK_WIDTH)

`endif

// ==== src/wh_flit_pkg.sv ====
/*
  Wormhole flit types
  Describes one link word: the header layout and a union that lets
  the same 16 bits be read as a header or as raw body data.
*/

`default_nettype none

`include "wh_settings.svh"

package wh_flit_pkg;

  // Header bits left over after len and cord
  localparam int hdr_payload_width = `WH_LINK_WIDTH - `WH_LEN_WIDTH - `WH_CORD_WIDTH;

  // cord sits in the low bits, same as in the assembled packet
  typedef struct packed {
    logic [hdr_payload_width-1:0] payload;
    logic [`WH_LEN_WIDTH-1:0]     len;
    logic [`WH_CORD_WIDTH-1:0]    cord;
  } wh_header_s;

  // First flit of a packet is decoded as a header, the rest as raw data
  typedef union packed {
    wh_header_s                header;
    logic [`WH_LINK_WIDTH-1:0] raw;
  } wh_flit_u;

endpackage

`default_nettype wire

// ==== src/wh_packet_pkg.sv ====
/*
  Wormhole packet types
  Describes the assembled packet word handed from the deserializers
  to the merge stage, and the flit index used while assembling it.
*/

`default_nettype none

`include "wh_settings.svh"

package wh_packet_pkg;

  // Everything above the len and cord fields
  localparam int pkt_payload_width = `WH_PACKET_WIDTH - `WH_LEN_WIDTH - `WH_CORD_WIDTH;

  // Flit index within a packet, 0 is the header
  typedef logic [`WH_LEN_WIDTH-1:0] wh_flit_cnt_t;

  // Packet = {payload, length, cord}
  typedef struct packed {
    logic [pkt_payload_width-1:0] payload;
    logic [`WH_LEN_WIDTH-1:0]     len;
    logic [`WH_CORD_WIDTH-1:0]    cord;
  } wh_packet_s;

endpackage

`default_nettype wire

// ==== src/wh_flit_deserializer.sv ====
/*
  Wormhole flit deserializer
  Gathers a header flit and its body flits from one link into one
  packet word. A single holding slot stores the finished packet
  until the consumer takes it; the link is stalled meanwhile.
  Slots a short packet leaves unused read as zero.
*/

`timescale 1ns/1ns
`default_nettype none

`include "wh_settings.svh"

module wh_flit_deserializer
  (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  wh_flit_pkg::wh_flit_u     data_i,
    input  logic                      v_i,
    output logic                      ready_o,

    output wh_packet_pkg::wh_packet_s packet_o,
    output logic                      v_o,
    input  logic                      yumi_i
  );

  import wh_packet_pkg::*;

  // Index of the slot the next flit lands in
  wh_flit_cnt_t cnt_r;
  // Number of body flits announced by the header
  wh_flit_cnt_t len_r;
  logic         full_r;

  logic [`WH_MAX_FLITS-1:0][`WH_LINK_WIDTH-1:0] slots_r;

  logic accept;
  logic is_header;
  logic last_flit;

  assign accept    = v_i & ready_o;
  assign is_header = (cnt_r == '0);

  // A len 0 header is its own last flit
  assign last_flit = is_header ? (data_i.header.len == '0) : (cnt_r == len_r);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cnt_r  <= '0;
      len_r  <= '0;
      full_r <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        if (is_header)
        begin
          len_r <= data_i.header.len;
        end
        if (last_flit)
        begin
          cnt_r <= '0;
        end
        else
        begin
          cnt_r <= cnt_r + wh_flit_cnt_t'(1);
        end
      end

      // No flit is accepted while full, so set and clear never collide
      if (accept && last_flit)
      begin
        full_r <= 1'b1;
      end
      else if (yumi_i)
      begin
        full_r <= 1'b0;
      end
    end
  end

  // Assembly register
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (is_header)
      begin
        // Wipe the previous packet, then drop the header in slot 0
        slots_r    <= '0;
        slots_r[0] <= data_i.raw;
      end
      else
      begin
        slots_r[cnt_r] <= data_i.raw;
      end
    end
  end

  assign ready_o  = ~full_r;
  assign v_o      = full_r;
  assign packet_o = slots_r;

endmodule

`default_nettype wire

// ==== src/wh_packet_merge.sv ====
/*
  Wormhole packet merge
  Round-robin merge of two deserialized packet streams onto one
  valid/yumi output. Purely combinational on the data path; only
  the priority pointer is stored, and it moves on consumption.
*/

`timescale 1ns/1ns
`default_nettype none

module wh_packet_merge
  (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  wh_packet_pkg::wh_packet_s pkt0_i,
    input  logic                      v0_i,
    output logic                      yumi0_o,

    input  wh_packet_pkg::wh_packet_s pkt1_i,
    input  logic                      v1_i,
    output logic                      yumi1_o,

    output wh_packet_pkg::wh_packet_s packet_o,
    output logic                      v_o,
    input  logic                      yumi_i
  );

  // Low favors stream 0, high favors stream 1
  logic prio_r;
  logic grant1;
  logic consumed;

  // Stream 1 wins when it is the only one valid, or when both are
  // valid and the pointer names it
  assign grant1 = v1_i & (~v0_i | prio_r);

  assign v_o      = v0_i | v1_i;
  assign packet_o = grant1 ? pkt1_i : pkt0_i;

  // yumi only goes back to the stream actually presented
  assign yumi0_o = yumi_i & ~grant1;
  assign yumi1_o = yumi_i & grant1;

  assign consumed = yumi_i & v_o;

  // Inputs hold while waiting and the pointer only moves here, so
  // the grant is stable until the output is taken
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      prio_r <= 1'b0;
    end
    else if (consumed)
    begin
      // Hand priority to the stream that was not served
      prio_r <= ~grant1;
    end
  end

endmodule

`default_nettype wire

// ==== src/wh_endpoint_rx.sv ====
/*
  Wormhole endpoint, receive side
  Two links, each with its own deserializer, merged round robin
  into a single packet stream for the local consumer.
*/

`timescale 1ns/1ns
`default_nettype none

`include "wh_settings.svh"

module wh_endpoint_rx
  (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  logic [`WH_LINK_WIDTH-1:0] link0_data_i,
    input  logic                      link0_v_i,
    output logic                      link0_ready_o,

    input  logic [`WH_LINK_WIDTH-1:0] link1_data_i,
    input  logic                      link1_v_i,
    output logic                      link1_ready_o,

    output wh_packet_pkg::wh_packet_s packet_o,
    output logic                      v_o,
    input  logic                      yumi_i
  );

  import wh_packet_pkg::*;

  wh_packet_s pkt0;
  wh_packet_s pkt1;
  logic       v0;
  logic       v1;
  logic       yumi0;
  logic       yumi1;

  // Router local port
  wh_flit_deserializer deser0
    (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .data_i   (link0_data_i),
      .v_i      (link0_v_i),
      .ready_o  (link0_ready_o),
      .packet_o (pkt0),
      .v_o      (v0),
      .yumi_i   (yumi0)
    );

  // Auxiliary port
  wh_flit_deserializer deser1
    (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .data_i   (link1_data_i),
      .v_i      (link1_v_i),
      .ready_o  (link1_ready_o),
      .packet_o (pkt1),
      .v_o      (v1),
      .yumi_i   (yumi1)
    );

  wh_packet_merge merge
    (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .pkt0_i   (pkt0),
      .v0_i     (v0),
      .yumi0_o  (yumi0),
      .pkt1_i   (pkt1),
      .v1_i     (v1),
      .yumi1_o  (yumi1),
      .packet_o (packet_o),
      .v_o      (v_o),
      .yumi_i   (yumi_i)
    );

endmodule

`default_nettype wire

// ==== sim/wh_endpoint_rx_tb.sv ====
/*
  Wormhole endpoint receive side testbench
  Directed tests for reset state, short and long packets, round-robin
  order, back-pressure and a random two-link stream. Expected packet
  words are built from the header-low, body-above layout rule.
*/

`timescale 1ns/1ns
`default_nettype none

`include "wh_settings.svh"

module wh_endpoint_rx_tb;

  import wh_flit_pkg::*;
  import wh_packet_pkg::*;

  localparam int stream_pkts = 40;
  localparam int stall_limit = 1000;
  localparam int wait_limit  = 1000;

  // Worst case flit count over tests 2 to 5 and the random stream
  localparam int total_flits = 1 + 2 * 4 + 4 * 2 + 3 * 3 + 2 * stream_pkts * `WH_MAX_FLITS;
  localparam int watchdog_ns = total_flits * 40 * 8;

  logic                      clk_i = 1'b0;
  logic                      reset_i;
  logic [`WH_LINK_WIDTH-1:0] link0_data_i;
  logic                      link0_v_i;
  logic                      link0_ready_o;
  logic [`WH_LINK_WIDTH-1:0] link1_data_i;
  logic                      link1_v_i;
  logic                      link1_ready_o;
  wh_packet_s                packet_o;
  logic                      v_o;
  logic                      yumi_i;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] lcg_state = 32'd81527;

  // Expected packets per link, and the link each output packet came from
  wh_packet_s exp_q0[$];
  wh_packet_s exp_q1[$];
  logic       order_q[$];

  wh_endpoint_rx dut
    (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .link0_data_i  (link0_data_i),
      .link0_v_i     (link0_v_i),
      .link0_ready_o (link0_ready_o),
      .link1_data_i  (link1_data_i),
      .link1_v_i     (link1_v_i),
      .link1_ready_o (link1_ready_o),
      .packet_o      (packet_o),
      .v_o           (v_o),
      .yumi_i        (yumi_i)
    );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[30:16]) % n;
  endfunction

  task automatic check_packet(input wh_packet_s got, input wh_packet_s exp, input string msg);
    checks = checks + 1;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    checks = checks + 1;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic drive_link(input int link, input logic [`WH_LINK_WIDTH-1:0] data,
                            input logic v);
    if (link == 0)
    begin
      link0_data_i = data;
      link0_v_i    = v;
    end
    else
    begin
      link1_data_i = data;
      link1_v_i    = v;
    end
  endtask

  function automatic logic link_ready(input int link);
    return (link == 0) ? link0_ready_o : link1_ready_o;
  endfunction

  task automatic apply_reset();
    reset_i = 1'b1;
    yumi_i  = 1'b0;
    drive_link(0, '0, 1'b0);
    drive_link(1, '0, 1'b0);
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
  endtask

  // Builds one packet, queues its expected word, then sends it flit by flit
  task automatic send_packet(input int link, input wh_flit_cnt_t len, input int gap_max);
    wh_flit_u                    hdr;
    logic [31:0]                 r;
    logic [`WH_LINK_WIDTH-1:0]   flits[`WH_MAX_FLITS];
    logic [`WH_PACKET_WIDTH-1:0] word;
    int                          i;
    int                          g;
    int                          gap;
    int                          stall;
    logic                        rdy;

    r = lcg_next();
    hdr.raw = r[31:16];
    hdr.header.len = len;
    // Top cord bit tells the consumer which link a packet came from
    hdr.header.cord = {(link != 0), r[3:0]};
    word = '0;
    flits[0] = hdr.raw;
    word[`WH_LINK_WIDTH-1:0] = hdr.raw;
    for (i = 1; i <= int'(len); i++)
    begin
      r = lcg_next();
      flits[i] = r[31:16];
      word[i*`WH_LINK_WIDTH +: `WH_LINK_WIDTH] = flits[i];
    end
    if (link == 0)
      exp_q0.push_back(wh_packet_s'(word));
    else
      exp_q1.push_back(wh_packet_s'(word));

    for (i = 0; i <= int'(len); i++)
    begin
      gap = (gap_max > 0) ? rand_below(gap_max + 1) : 0;
      for (g = 0; g < gap; g++)
      begin
        @(posedge clk_i);
        #1;
      end
      drive_link(link, flits[i], 1'b1);
      stall = 0;
      rdy = link_ready(link);
      @(posedge clk_i);
      while (!rdy)
      begin
        #1;
        stall = stall + 1;
        if (stall > stall_limit)
        begin
          $display("Link %0d stalled: flit %0d not accepted within %0d cycles",
                   link, i, stall_limit);
          errors = errors + 1;
          drive_link(link, '0, 1'b0);
          return;
        end
        rdy = link_ready(link);
        @(posedge clk_i);
      end
      #1;
      drive_link(link, '0, 1'b0);
    end
  endtask

  // Takes count packets from the output and checks each against its link queue
  task automatic receive_packets(input int count, input int gap_max);
    int         n;
    int         g;
    int         gap;
    int         waited;
    logic       src;
    wh_packet_s got;

    for (n = 0; n < count; n++)
    begin
      waited = 0;
      while (!v_o && waited < wait_limit)
      begin
        @(posedge clk_i);
        #1;
        waited = waited + 1;
      end
      if (!v_o)
      begin
        $display("Missing packet: output idle for %0d cycles while waiting for packet %0d of %0d",
                 wait_limit, n + 1, count);
        errors = errors + 1;
        return;
      end
      gap = (gap_max > 0) ? rand_below(gap_max + 1) : 0;
      for (g = 0; g < gap; g++)
      begin
        @(posedge clk_i);
        #1;
      end
      got = packet_o;
      src = got.cord[`WH_CORD_WIDTH-1];
      order_q.push_back(src);
      if (src == 1'b0 && exp_q0.size() == 0)
      begin
        $display("Unexpected packet from link 0 with cord %0d", got.cord);
        errors = errors + 1;
      end
      else if (src == 1'b1 && exp_q1.size() == 0)
      begin
        $display("Unexpected packet from link 1 with cord %0d", got.cord);
        errors = errors + 1;
      end
      else if (src == 1'b0)
        check_packet(got, exp_q0.pop_front(), "link 0 packet");
      else
        check_packet(got, exp_q1.pop_front(), "link 1 packet");
      yumi_i = 1'b1;
      @(posedge clk_i);
      #1;
      yumi_i = 1'b0;
    end
  endtask

  task automatic check_drained(input string name);
    if (exp_q0.size() != 0)
    begin
      $display("%s: %0d packet(s) sent on link 0 never arrived", name, exp_q0.size());
      errors = errors + 1;
      exp_q0.delete();
    end
    if (exp_q1.size() != 0)
    begin
      $display("%s: %0d packet(s) sent on link 1 never arrived", name, exp_q1.size());
      errors = errors + 1;
      exp_q1.delete();
    end
  endtask

  task test_reset_state;
    check_bit(v_o, 1'b0, "v_o after reset");
    check_bit(link0_ready_o, 1'b1, "link0_ready_o after reset");
    check_bit(link1_ready_o, 1'b1, "link1_ready_o after reset");
  endtask

  task test_single_flit;
    send_packet(0, 2'd0, 0);
    check_bit(v_o, 1'b1, "v_o one cycle after a len 0 header");
    receive_packets(1, 0);
    check_drained("single flit");
  endtask

  task test_max_length;
    send_packet(0, 2'd3, 0);
    receive_packets(1, 0);
    send_packet(1, 2'd3, 0);
    receive_packets(1, 0);
    check_drained("max length");
  endtask

  task test_round_robin;
    int   k;
    logic expect_link;

    apply_reset();
    order_q.delete();
    // Both slots fill together while the pointer favors link 0
    fork
      send_packet(0, 2'd1, 0);
      send_packet(1, 2'd1, 0);
    join
    receive_packets(1, 0);
    // Link 0 refills while link 1 still waits and the pointer now names link 1
    send_packet(0, 2'd1, 0);
    receive_packets(1, 0);
    send_packet(1, 2'd1, 0);
    receive_packets(2, 0);
    expect_link = 1'b0;
    if (order_q.size() != 4)
    begin
      $display("Round robin: %0d packets seen where 4 were sent", order_q.size());
      errors = errors + 1;
    end
    else
    begin
      for (k = 0; k < 4; k++)
      begin
        check_bit(order_q[k], expect_link, "round robin grant order");
        expect_link = ~expect_link;
      end
    end
    check_drained("round robin");
  endtask

  task test_back_pressure;
    send_packet(0, 2'd2, 0);
    // Second link 0 packet waits behind the full slot
    fork
      send_packet(0, 2'd2, 0);
    join_none
    send_packet(1, 2'd2, 0);
    check_bit(link0_ready_o, 1'b0, "link 0 stalled behind its full slot");
    check_bit(link1_ready_o, 1'b0, "link 1 slot filled under back-pressure");
    check_bit(v_o, 1'b1, "v_o held while yumi_i low");
    receive_packets(3, 0);
    check_drained("back-pressure");
  endtask

  task test_random_stream;
    int i;
    int j;

    fork
      for (i = 0; i < stream_pkts; i++)
        send_packet(0, wh_flit_cnt_t'(rand_below(`WH_MAX_FLITS)), 3);
      for (j = 0; j < stream_pkts; j++)
        send_packet(1, wh_flit_cnt_t'(rand_below(`WH_MAX_FLITS)), 3);
      receive_packets(2 * stream_pkts, 3);
    join
    check_drained("random stream");
  endtask

  initial
  begin
    apply_reset();
    test_reset_state();
    // Long packets first so the len 0 packet lands on a used slot
    test_max_length();
    test_single_flit();
    test_round_robin();
    test_back_pressure();
    test_random_stream();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("Timeout: run did not finish within %0d ns", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
src/wh_flit_pkg.sv
src/wh_packet_pkg.sv
src/wh_flit_deserializer.sv
src/wh_packet_merge.sv
src/wh_endpoint_rx.sv
sim/wh_endpoint_rx_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= wh_endpoint_rx_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS ?= --lint-only --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/wh_settings.svh

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the log holds the pass line
run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
